/* flist.f */
logic/mci_pkg.sv
logic/mci_sub_decode.sv
logic/mci_csr_block.sv
logic/mci_sram_ctrl.sv
logic/mci_trace_buffer.sv
logic/mci_mailbox.sv
logic/mci_sub_top.sv
testbench/mci_sub_tb.sv

/* logic/mci_csr_block.sv */
`timescale 1ns/1ps
`default_nettype none

module mci_csr_block (
    input logic clk,
    input logic reset,
    input logic csr_dv,
    input mci_pkg::addr_t req_addr,
    input logic req_write,
    input mci_pkg::data_t req_wdata,
    input logic soc_config_priv,
    output mci_pkg::data_t csr_rdata,
    output logic csr_hold,
    output logic csr_error,
    output mci_pkg::data_t soc_config
);

    // Offset inside the 4 KB window
    logic [11:0] offset;
    logic id_sel;
    logic scratch_sel;
    logic config_sel;
    // Write accepted by the block this cycle
    logic wr_en;
    mci_pkg::data_t scratch;

    assign offset = req_addr[11:0];
    assign id_sel = (offset == mci_pkg::csr_id_off);
    assign scratch_sel = (offset == mci_pkg::csr_scratch_off);
    assign config_sel = (offset == mci_pkg::csr_config_off);
    assign wr_en = csr_dv & req_write;

    // Zero wait states
    assign csr_hold = 1'b0;

    // ID is read-only and config needs the privileged user
    assign csr_error = wr_en & (id_sel | (config_sel & ~soc_config_priv));

    //////////////////////////////
    // Registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            scratch <= '0;
            soc_config <= '0;
        end else begin
            // Scratch is open to any user
            if (wr_en && scratch_sel) begin
                scratch <= req_wdata;
            end
            // Refused config writes leave the value alone
            if (wr_en && config_sel && soc_config_priv) begin
                soc_config <= req_wdata;
            end
        end
    end

    // Read mux with zero for unknown offsets
    always_comb begin
        case (offset)
            mci_pkg::csr_id_off: csr_rdata = mci_pkg::mci_id_value;
            mci_pkg::csr_scratch_off: csr_rdata = scratch;
            mci_pkg::csr_config_off: csr_rdata = soc_config;
            default: csr_rdata = '0;
        endcase
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Never stalls the master
    a_no_hold: assert property (@(posedge clk) disable iff (reset)
        csr_dv |-> !csr_hold);

endmodule

`default_nettype wire

/* logic/mci_mailbox.sv */
`timescale 1ns/1ps
`default_nettype none

module mci_mailbox (
    input logic clk,
    input logic reset,
    input logic mbox_dv,
    input mci_pkg::addr_t req_addr,
    input logic req_write,
    input mci_pkg::data_t req_wdata,
    input logic mcu_priv,
    output mci_pkg::data_t mbox_rdata,
    output logic mbox_hold,
    output logic mbox_error
);

    mci_pkg::data_t words [mci_pkg::mbox_words];
    // Set while someone owns the mailbox
    logic lock;
    logic [7:0] offset;
    mci_pkg::mbox_idx_t idx;
    logic lock_sel;
    logic release_sel;
    logic data_sel;
    logic data_ok;

    assign offset = req_addr[7:0];
    assign idx = offset[2 +: $bits(mci_pkg::mbox_idx_t)];
    assign lock_sel = (offset == mci_pkg::mbox_lock_off);
    assign release_sel = (offset == mci_pkg::mbox_release_off);
    assign data_sel = (offset >= mci_pkg::entry_base) &&
                      (offset < mci_pkg::entry_base + 4 * mci_pkg::mbox_words);

    // Data needs a held lock and an MCU user
    assign data_ok = lock & mcu_priv;

    assign mbox_hold = 1'b0;
    assign mbox_error = mbox_dv & data_sel & ~data_ok;

    // A lock read acquires it and a write of 1 frees it
    always_ff @(posedge clk) begin
        if (reset) begin
            lock <= 1'b0;
        end else if (mbox_dv && !req_write && lock_sel) begin
            lock <= 1'b1;
        end else if (mbox_dv && req_write && release_sel && req_wdata[0]) begin
            lock <= 1'b0;
        end
    end

    // Refused data writes are dropped
    always_ff @(posedge clk) begin
        if (mbox_dv && req_write && data_sel && data_ok) begin
            words[idx] <= req_wdata;
        end
    end

    // Lock read shows the state before acquiring
    always_comb begin
        mbox_rdata = '0;
        if (lock_sel) begin
            mbox_rdata = mci_pkg::data_t'(lock);
        end else if (data_sel && data_ok) begin
            mbox_rdata = words[idx];
        end
    end

endmodule

`default_nettype wire

/* logic/mci_pkg.sv */
`default_nettype none

package mci_pkg;

    //////////////////////////////
    // Widths with a meaning
    //////////////////////////////

    // Byte address of a request
    typedef logic [23:0] addr_t;
    // Read and write data word
    typedef logic [31:0] data_t;
    // Request user field, also the strap format
    typedef logic [7:0] user_t;

    // Bytes per KB
    localparam int kb = 1024;

    //////////////////////////////
    // Address map
    //////////////////////////////

    // Register block, 4 KB
    localparam addr_t csr_start = 24'h00_0000;
    localparam addr_t csr_end = 24'h00_0FFF;

    // Trace buffer
    localparam addr_t trace_start = 24'h01_0000;
    localparam addr_t trace_end = 24'h01_00FF;

    // Mailboxes, one window each
    localparam addr_t mbox0_start = 24'h40_0000;
    localparam addr_t mbox0_end = 24'h40_00FF;
    localparam addr_t mbox1_start = 24'h80_0000;
    localparam addr_t mbox1_end = 24'h80_00FF;

    // Local SRAM, sized in KB
    localparam int sram_size_kb = 4;
    localparam addr_t sram_start = 24'hC0_0000;
    localparam addr_t sram_end = addr_t'(sram_start + sram_size_kb * kb - 1);

    //////////////////////////////
    // Target sizes and offsets
    //////////////////////////////

    localparam int trace_depth = 16;
    localparam int mbox_words = 16;
    localparam int sram_words = sram_size_kb * kb / 4;

    // Index widths follow the sizes
    typedef logic [$clog2(trace_depth)-1:0] trace_ptr_t;
    typedef logic [$clog2(mbox_words)-1:0] mbox_idx_t;
    typedef logic [$clog2(sram_words)-1:0] sram_idx_t;

    // Register block offsets
    localparam logic [11:0] csr_id_off = 12'h000;
    localparam logic [11:0] csr_scratch_off = 12'h004;
    localparam logic [11:0] csr_config_off = 12'h008;

    // Offsets inside trace and mailbox windows
    localparam logic [7:0] trace_ptr_off = 8'h00;
    localparam logic [7:0] mbox_lock_off = 8'h00;
    localparam logic [7:0] mbox_release_off = 8'h04;
    // First array word in both
    localparam logic [7:0] entry_base = 8'h40;

    // "MCI1" in ASCII
    localparam data_t mci_id_value = 32'h4D43_4931;

    // SRAM read sequencing
    typedef enum logic {
        sram_idle,
        sram_read_wait
    } sram_state_e;

endpackage

`default_nettype wire

/* logic/mci_sram_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module mci_sram_ctrl (
    input logic clk,
    input logic reset,
    input logic sram_dv,
    input mci_pkg::addr_t req_addr,
    input logic req_write,
    input mci_pkg::data_t req_wdata,
    input logic sram_config_priv,
    output mci_pkg::data_t sram_rdata,
    output logic sram_hold,
    output logic sram_error
);

    // Word array
    mci_pkg::data_t mem [mci_pkg::sram_words];
    mci_pkg::sram_idx_t idx;
    mci_pkg::sram_state_e state;
    logic rd_req;
    logic wr_req;

    // Word index from the byte address
    assign idx = req_addr[2 +: $bits(mci_pkg::sram_idx_t)];
    assign rd_req = sram_dv & ~req_write;
    assign wr_req = sram_dv & req_write;

    // First read cycle waits on the array
    assign sram_hold = rd_req & (state == mci_pkg::sram_idle);

    // Writes need the SRAM config user
    assign sram_error = wr_req & ~sram_config_priv;

    //////////////////////////////
    // Read FSM
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mci_pkg::sram_idle;
        end else begin
            case (state)
                mci_pkg::sram_idle: begin
                    if (rd_req) begin
                        state <= mci_pkg::sram_read_wait;
                    end
                end
                // Data out now, read completes
                mci_pkg::sram_read_wait: begin
                    state <= mci_pkg::sram_idle;
                end
                default: begin
                    state <= mci_pkg::sram_idle;
                end
            endcase
        end
    end

    //////////////////////////////
    // Array port
    //////////////////////////////

    always_ff @(posedge clk) begin
        // Capture on the held cycle
        if (rd_req && state == mci_pkg::sram_idle) begin
            sram_rdata <= mem[idx];
        end
        if (wr_req && sram_config_priv) begin
            mem[idx] <= req_wdata;
        end
    end

    // One wait state, never two
    a_hold_single: assert property (@(posedge clk) disable iff (reset)
        sram_hold |=> !sram_hold);

endmodule

`default_nettype wire

/* logic/mci_sub_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module mci_sub_decode (
    input logic clk,
    input logic reset,

    // Request from the system master
    input logic req_dv,
    input mci_pkg::addr_t req_addr,
    input mci_pkg::user_t req_user,
    input logic req_write,
    input mci_pkg::data_t req_wdata,

    // Privileged user straps
    input mci_pkg::user_t strap_mcu_lsu_user,
    input mci_pkg::user_t strap_mcu_ifu_user,
    input mci_pkg::user_t strap_sram_config_user,
    input mci_pkg::user_t strap_soc_config_user,

    // Target responses
    input mci_pkg::data_t csr_rdata,
    input logic csr_hold,
    input logic csr_error,
    input mci_pkg::data_t trace_rdata,
    input logic trace_hold,
    input logic trace_error,
    input mci_pkg::data_t mbox0_rdata,
    input logic mbox0_hold,
    input logic mbox0_error,
    input mci_pkg::data_t mbox1_rdata,
    input logic mbox1_hold,
    input logic mbox1_error,
    input mci_pkg::data_t sram_rdata,
    input logic sram_hold,
    input logic sram_error,

    // Per-target strobes
    output logic csr_dv,
    output logic trace_dv,
    output logic mbox0_dv,
    output logic mbox1_dv,
    output logic sram_dv,

    // Response to the master
    output mci_pkg::data_t resp_rdata,
    output logic resp_hold,
    output logic resp_error,

    // Privilege strobes
    output logic mcu_lsu_req,
    output logic mcu_ifu_req,
    output logic mcu_priv,
    output logic soc_config_priv,
    output logic sram_config_priv
);

    // Config strap special cases
    logic soc_config_disable;
    logic soc_config_force;
    logic soc_config_match;

    //////////////////////////////
    // Window decode
    //////////////////////////////

    always_comb begin
        csr_dv = req_dv & (req_addr inside {[mci_pkg::csr_start : mci_pkg::csr_end]});
        trace_dv = req_dv & (req_addr inside {[mci_pkg::trace_start : mci_pkg::trace_end]});
        mbox0_dv = req_dv & (req_addr inside {[mci_pkg::mbox0_start : mci_pkg::mbox0_end]});
        mbox1_dv = req_dv & (req_addr inside {[mci_pkg::mbox1_start : mci_pkg::mbox1_end]});
        sram_dv = req_dv & (req_addr inside {[mci_pkg::sram_start : mci_pkg::sram_end]});
    end

    //////////////////////////////
    // Response mux
    //////////////////////////////

    // A miss falls through to zero data
    assign resp_rdata = sram_dv  ? sram_rdata  :
                        trace_dv ? trace_rdata :
                        csr_dv   ? csr_rdata   :
                        mbox0_dv ? mbox0_rdata :
                        mbox1_dv ? mbox1_rdata :
                        '0;

    // Only the selected target may stall
    assign resp_hold = (csr_dv & csr_hold) | (trace_dv & trace_hold) |
                       (mbox0_dv & mbox0_hold) | (mbox1_dv & mbox1_hold) |
                       (sram_dv & sram_hold);

    // No error on a miss, the system keeps running
    assign resp_error = (csr_dv & csr_error) | (trace_dv & trace_error) |
                        (mbox0_dv & mbox0_error) | (mbox1_dv & mbox1_error) |
                        (sram_dv & sram_error);

    //////////////////////////////
    // Privileged users
    //////////////////////////////

    // All zeros turns config privilege off
    assign soc_config_disable = ~|strap_soc_config_user;
    // All ones grants it to everyone
    assign soc_config_force = &strap_soc_config_user;
    assign soc_config_match = (req_user == strap_soc_config_user);

    assign soc_config_priv = req_dv &
                             ((soc_config_match & ~soc_config_disable) | soc_config_force);

    // Exact user match against each strap
    assign mcu_lsu_req = req_dv & (req_user == strap_mcu_lsu_user);
    assign mcu_ifu_req = req_dv & (req_user == strap_mcu_ifu_user);
    assign mcu_priv = mcu_lsu_req | mcu_ifu_req;
    assign sram_config_priv = req_dv & (req_user == strap_sram_config_user);

    //////////////////////////////
    // Checks
    //////////////////////////////

    // One target per request at most
    a_dv_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({csr_dv, trace_dv, mbox0_dv, mbox1_dv, sram_dv}));

    // Stall only against a live request
    a_hold_req: assert property (@(posedge clk) disable iff (reset)
        resp_hold |-> req_dv);

    // Master freezes the request across a stall
    a_hold_frozen: assert property (@(posedge clk) disable iff (reset)
        resp_hold |=> req_dv && $stable({req_addr, req_user, req_write, req_wdata}));

    // Windows ascend without overlap
    initial begin
        a_map_order: assert (mci_pkg::csr_end < mci_pkg::trace_start &&
                             mci_pkg::trace_end < mci_pkg::mbox0_start &&
                             mci_pkg::mbox0_end < mci_pkg::mbox1_start &&
                             mci_pkg::mbox1_end < mci_pkg::sram_start)
            else $error("address windows overlap");
    end

endmodule

`default_nettype wire

/* logic/mci_sub_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mci_sub_top (
    input logic clk,
    input logic reset,

    // Request from the system master
    input logic req_dv,
    input mci_pkg::addr_t req_addr,
    input mci_pkg::user_t req_user,
    input logic req_write,
    input mci_pkg::data_t req_wdata,

    // Straps
    input mci_pkg::user_t strap_mcu_lsu_user,
    input mci_pkg::user_t strap_mcu_ifu_user,
    input mci_pkg::user_t strap_sram_config_user,
    input mci_pkg::user_t strap_soc_config_user,

    // Trace capture
    input logic trace_valid,
    input mci_pkg::data_t trace_data,

    // Response and exports
    output mci_pkg::data_t resp_rdata,
    output logic resp_hold,
    output logic resp_error,
    output logic mcu_lsu_req,
    output logic mcu_ifu_req,
    output logic mcu_priv,
    output mci_pkg::data_t soc_config
);

    //////////////////////////////
    // Decoder to target wiring
    //////////////////////////////

    logic csr_dv;
    logic trace_dv;
    logic mbox0_dv;
    logic mbox1_dv;
    logic sram_dv;
    mci_pkg::data_t csr_rdata;
    mci_pkg::data_t trace_rdata;
    mci_pkg::data_t mbox0_rdata;
    mci_pkg::data_t mbox1_rdata;
    mci_pkg::data_t sram_rdata;
    logic csr_hold;
    logic trace_hold;
    logic mbox0_hold;
    logic mbox1_hold;
    logic sram_hold;
    logic csr_error;
    logic trace_error;
    logic mbox0_error;
    logic mbox1_error;
    logic sram_error;
    // Privilege strobes kept inside
    logic soc_config_priv;
    logic sram_config_priv;

    // Port names match the wires one to one
    mci_sub_decode decode_i (.*);
    mci_csr_block csr_i (.*);
    mci_trace_buffer trace_i (.*);
    mci_sram_ctrl sram_i (.*);

    // Two identical mailboxes on their own windows
    mci_mailbox mbox0_i (
        .clk(clk),
        .reset(reset),
        .mbox_dv(mbox0_dv),
        .req_addr(req_addr),
        .req_write(req_write),
        .req_wdata(req_wdata),
        .mcu_priv(mcu_priv),
        .mbox_rdata(mbox0_rdata),
        .mbox_hold(mbox0_hold),
        .mbox_error(mbox0_error)
    );

    mci_mailbox mbox1_i (
        .clk(clk),
        .reset(reset),
        .mbox_dv(mbox1_dv),
        .req_addr(req_addr),
        .req_write(req_write),
        .req_wdata(req_wdata),
        .mcu_priv(mcu_priv),
        .mbox_rdata(mbox1_rdata),
        .mbox_hold(mbox1_hold),
        .mbox_error(mbox1_error)
    );

endmodule

`default_nettype wire

/* logic/mci_trace_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module mci_trace_buffer (
    input logic clk,
    input logic reset,
    input logic trace_valid,
    input mci_pkg::data_t trace_data,
    input logic trace_dv,
    input mci_pkg::addr_t req_addr,
    input logic req_write,
    output mci_pkg::data_t trace_rdata,
    output logic trace_hold,
    output logic trace_error
);

    // Circular capture store
    mci_pkg::data_t entries [mci_pkg::trace_depth];
    mci_pkg::trace_ptr_t wr_ptr;
    logic [7:0] offset;
    logic entry_sel;

    assign offset = req_addr[7:0];
    // Entry i sits at entry_base + 4*i
    assign entry_sel = (offset >= mci_pkg::entry_base) &&
                       (offset < mci_pkg::entry_base + 4 * mci_pkg::trace_depth);

    // Capture side, one word per valid cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (trace_valid) begin
            // Wrap after the last entry
            wr_ptr <= (wr_ptr == mci_pkg::trace_ptr_t'(mci_pkg::trace_depth - 1)) ?
                      '0 : wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (trace_valid) begin
            entries[wr_ptr] <= trace_data;
        end
    end

    // Master side is read-only, no stall
    assign trace_hold = 1'b0;
    assign trace_error = trace_dv & req_write;

    // Pointer at offset 0, entries above
    always_comb begin
        trace_rdata = '0;
        if (offset == mci_pkg::trace_ptr_off) begin
            trace_rdata = mci_pkg::data_t'(wr_ptr);
        end else if (entry_sel) begin
            trace_rdata = entries[offset[2 +: $bits(mci_pkg::trace_ptr_t)]];
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module mci_sub_tb -o mci_sub_sim

# A failing run ends in $fatal, which gives a nonzero exit status
./obj_dir/mci_sub_sim

/* testbench/mci_sub_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mci_sub_tb;

    // Strapped users, plus one that matches nothing
    localparam mci_pkg::user_t lsu_user = 8'h11;
    localparam mci_pkg::user_t ifu_user = 8'h22;
    localparam mci_pkg::user_t sram_user = 8'h33;
    localparam mci_pkg::user_t cfg_user = 8'h44;
    localparam mci_pkg::user_t plain_user = 8'h55;
    localparam int trace_pushes = 20;
    // Longest stall the master tolerates
    localparam int max_wait = 8;

    logic clk;
    logic reset;
    logic req_dv;
    mci_pkg::addr_t req_addr;
    mci_pkg::user_t req_user;
    logic req_write;
    mci_pkg::data_t req_wdata;
    mci_pkg::user_t strap_mcu_lsu_user;
    mci_pkg::user_t strap_mcu_ifu_user;
    mci_pkg::user_t strap_sram_config_user;
    mci_pkg::user_t strap_soc_config_user;
    logic trace_valid;
    mci_pkg::data_t trace_data;
    mci_pkg::data_t resp_rdata;
    logic resp_hold;
    logic resp_error;
    logic mcu_lsu_req;
    logic mcu_ifu_req;
    logic mcu_priv;
    mci_pkg::data_t soc_config;

    //////////////////////////////
    // Stimulus table, one entry per request
    string row_name [$];
    mci_pkg::addr_t row_addr [$];
    mci_pkg::user_t row_user [$];
    logic row_write [$];
    mci_pkg::data_t row_wdata [$];
    mci_pkg::user_t row_strap [$];
    mci_pkg::data_t row_rdata [$];
    logic row_error [$];

    // Every word pushed into the trace buffer
    mci_pkg::data_t trace_model [trace_pushes];
    integer seed;

    mci_sub_top dut_i (.*);

    always #50 clk = ~clk;

    //////////////////////////////
    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s %s: expected %h, actual %h", name, what, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic add_row(input string name, input mci_pkg::addr_t addr,
                           input mci_pkg::user_t user, input logic write,
                           input mci_pkg::data_t wdata, input mci_pkg::user_t strap,
                           input mci_pkg::data_t rdata, input logic error);
        row_name.push_back(name);
        row_addr.push_back(addr);
        row_user.push_back(user);
        row_write.push_back(write);
        row_wdata.push_back(wdata);
        row_strap.push_back(strap);
        row_rdata.push_back(rdata);
        row_error.push_back(error);
    endtask

    // SRAM reads stall one cycle, all else answers at once
    function automatic int expected_wait(input mci_pkg::addr_t addr, input logic write);
        if (!write && addr >= 24'hC0_0000 && addr <= 24'hC0_0FFF) begin
            return 1;
        end
        return 0;
    endfunction

    // Latest word that landed in a circular slot
    function automatic mci_pkg::data_t newest_trace_word(input int slot);
        int k;
        k = slot;
        while (k + mci_pkg::trace_depth < trace_pushes) begin
            k = k + mci_pkg::trace_depth;
        end
        return trace_model[k];
    endfunction

    task automatic push_trace();
        for (int i = 0; i < trace_pushes; i++) begin
            @(posedge clk);
            trace_model[i] = $random(seed);
            trace_valid <= 1'b1;
            trace_data <= trace_model[i];
        end
        @(posedge clk);
        trace_valid <= 1'b0;
    endtask

    //////////////////////////////
    // Mailbox sequences
    task automatic mbox_lock_rows(input string tag, input mci_pkg::addr_t base);
        add_row({tag, " data before lock"}, base + 24'h40, lsu_user, 1'b0, '0, cfg_user,
                '0, 1'b1);
        // First read takes the lock, second sees it taken
        add_row({tag, " first lock read"}, base, lsu_user, 1'b0, '0, cfg_user, '0, 1'b0);
        add_row({tag, " second lock read"}, base, lsu_user, 1'b0, '0, cfg_user, 32'h1, 1'b0);
    endtask

    task automatic mbox_data_rows(input string tag, input mci_pkg::addr_t base,
                                  input mci_pkg::data_t word);
        add_row({tag, " data write"}, base + 24'h44, lsu_user, 1'b1, word, cfg_user, '0, 1'b0);
        add_row({tag, " data read"}, base + 24'h44, ifu_user, 1'b0, '0, cfg_user, word, 1'b0);
        add_row({tag, " plain data write"}, base + 24'h44, plain_user, 1'b1, ~word, cfg_user,
                '0, 1'b1);
        add_row({tag, " plain data read"}, base + 24'h44, plain_user, 1'b0, '0, cfg_user,
                '0, 1'b1);
        add_row({tag, " data kept"}, base + 24'h44, lsu_user, 1'b0, '0, cfg_user, word, 1'b0);
        add_row({tag, " release"}, base + 24'h04, lsu_user, 1'b1, 32'h1, cfg_user, '0, 1'b0);
        add_row({tag, " data after release"}, base + 24'h44, lsu_user, 1'b0, '0, cfg_user,
                '0, 1'b1);
    endtask

    task automatic build_table();
        // Routing and the silent miss
        add_row("id read", 24'h00_0000, plain_user, 1'b0, '0, cfg_user, 32'h4D43_4931, 1'b0);
        add_row("id write", 24'h00_0000, plain_user, 1'b1, 32'h1234, cfg_user, '0, 1'b1);
        add_row("scratch write", 24'h00_0004, plain_user, 1'b1, 32'hA5A5_0001, cfg_user,
                '0, 1'b0);
        add_row("scratch read", 24'h00_0004, lsu_user, 1'b0, '0, cfg_user, 32'hA5A5_0001, 1'b0);
        add_row("miss read", 24'h20_0000, lsu_user, 1'b0, '0, cfg_user, '0, 1'b0);
        // SRAM
        add_row("sram write", 24'hC0_0010, sram_user, 1'b1, 32'h5A5A_1234, cfg_user, '0, 1'b0);
        add_row("sram read", 24'hC0_0010, plain_user, 1'b0, '0, cfg_user, 32'h5A5A_1234, 1'b0);
        add_row("sram top write", 24'hC0_0FFC, sram_user, 1'b1, 32'h0BAD_F00D, cfg_user,
                '0, 1'b0);
        add_row("sram top read", 24'hC0_0FFC, lsu_user, 1'b0, '0, cfg_user, 32'h0BAD_F00D, 1'b0);
        add_row("sram refused write", 24'hC0_0010, lsu_user, 1'b1, 32'hDEAD_BEEF, cfg_user,
                '0, 1'b1);
        add_row("sram kept read", 24'hC0_0010, plain_user, 1'b0, '0, cfg_user, 32'h5A5A_1234,
                1'b0);
        // Config strap matches one user
        add_row("cfg match write", 24'h00_0008, cfg_user, 1'b1, 32'hC0DE_0001, cfg_user,
                '0, 1'b0);
        add_row("cfg match read", 24'h00_0008, plain_user, 1'b0, '0, cfg_user, 32'hC0DE_0001,
                1'b0);
        add_row("cfg other write", 24'h00_0008, plain_user, 1'b1, 32'hC0DE_0002, cfg_user,
                '0, 1'b1);
        add_row("cfg other read", 24'h00_0008, plain_user, 1'b0, '0, cfg_user, 32'hC0DE_0001,
                1'b0);
        // All zeros, nobody may write
        add_row("cfg off write", 24'h00_0008, cfg_user, 1'b1, 32'hC0DE_0003, 8'h00, '0, 1'b1);
        add_row("cfg off zero user write", 24'h00_0008, 8'h00, 1'b1, 32'hC0DE_0004, 8'h00,
                '0, 1'b1);
        add_row("cfg off read", 24'h00_0008, plain_user, 1'b0, '0, 8'h00, 32'hC0DE_0001, 1'b0);
        // All ones, everybody may write
        add_row("cfg forced write", 24'h00_0008, plain_user, 1'b1, 32'hC0DE_0005, 8'hFF,
                '0, 1'b0);
        add_row("cfg forced read", 24'h00_0008, plain_user, 1'b0, '0, 8'hFF, 32'hC0DE_0005, 1'b0);
        add_row("cfg forced lsu write", 24'h00_0008, lsu_user, 1'b1, 32'hC0DE_0006, 8'hFF,
                '0, 1'b0);
        add_row("cfg forced read 2", 24'h00_0008, plain_user, 1'b0, '0, 8'hFF, 32'hC0DE_0006,
                1'b0);
        // Trace buffer after the pushes
        add_row("trace pointer", 24'h01_0000, plain_user, 1'b0, '0, cfg_user,
                trace_pushes % mci_pkg::trace_depth, 1'b0);
        for (int j = 0; j < mci_pkg::trace_depth; j++) begin
            add_row($sformatf("trace entry %0d", j), mci_pkg::addr_t'(24'h01_0040 + 4 * j),
                    plain_user, 1'b0, '0, cfg_user, newest_trace_word(j), 1'b0);
        end
        add_row("trace write", 24'h01_0000, lsu_user, 1'b1, 32'h1, cfg_user, '0, 1'b1);
        // mbox1 lock reads free while mbox0 is held
        mbox_lock_rows("mbox0", 24'h40_0000);
        mbox_lock_rows("mbox1", 24'h80_0000);
        mbox_data_rows("mbox0", 24'h40_0000, 32'h0000_AB00);
        mbox_data_rows("mbox1", 24'h80_0000, 32'h0000_CD01);
    endtask

    //////////////////////////////
    task automatic run_row(input int i);
        int waits;
        @(posedge clk);
        req_dv <= 1'b1;
        req_addr <= row_addr[i];
        req_user <= row_user[i];
        req_write <= row_write[i];
        req_wdata <= row_wdata[i];
        strap_soc_config_user <= row_strap[i];
        waits = 0;
        @(negedge clk);
        // Count stall cycles until the request completes
        while (resp_hold) begin
            waits++;
            if (waits > max_wait) begin
                $display("request %s never completed, hold stayed high", row_name[i]);
                $display("TEST RESULT: FAIL");
                $fatal(1, "response timeout");
            end
            @(negedge clk);
        end
        check_value(row_name[i], "hold cycles", expected_wait(row_addr[i], row_write[i]), waits);
        check_value(row_name[i], "error", 32'(row_error[i]), 32'(resp_error));
        if (!row_write[i]) begin
            check_value(row_name[i], "rdata", row_rdata[i], resp_rdata);
        end
        if (!row_write[i] && row_addr[i] == 24'h00_0008) begin
            check_value(row_name[i], "soc_config", row_rdata[i], soc_config);
        end
        // Privilege outputs follow the user field
        check_value(row_name[i], "mcu_lsu_req", 32'(row_user[i] == lsu_user), 32'(mcu_lsu_req));
        check_value(row_name[i], "mcu_ifu_req", 32'(row_user[i] == ifu_user), 32'(mcu_ifu_req));
        check_value(row_name[i], "mcu_priv",
                    32'(row_user[i] == lsu_user || row_user[i] == ifu_user), 32'(mcu_priv));
        // Completion edge, then one idle cycle
        @(posedge clk);
        req_dv <= 1'b0;
        @(negedge clk);
        check_value(row_name[i], "idle hold", 32'h0, 32'(resp_hold));
        check_value(row_name[i], "idle mcu_priv", 32'h0,
                    32'({mcu_lsu_req, mcu_ifu_req, mcu_priv}));
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        req_dv = 1'b0;
        req_addr = '0;
        req_user = '0;
        req_write = 1'b0;
        req_wdata = '0;
        strap_mcu_lsu_user = lsu_user;
        strap_mcu_ifu_user = ifu_user;
        strap_sram_config_user = sram_user;
        strap_soc_config_user = cfg_user;
        trace_valid = 1'b0;
        trace_data = '0;
        seed = 59;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        push_trace();
        build_table();
        for (int i = 0; i < row_name.size(); i++) begin
            run_row(i);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
